// ==== adc_controller.sv ====
`timescale 1ns/1ps

module adc_controller #(
	parameter int MIN_T_CYCLE = 85,   // 5 us at a 17 MHz serial clock
	parameter int OS_INIT     = 1     // oversampling code out of reset
) (
	input  logic                clk_in,           // adc serial clock, 17 MHz max
	input  logic                reset_in,
	input  logic                busy_in,          // from adc
	input  logic                data_a_in,        // serial line a
	input  logic                data_b_in,        // serial line b
	input  adc_pkg::os_t        os_in,            // front panel
	input  logic                update_in,        // front panel latch pulse
	input  logic                cstart_in,        // start continuous conversion
	output adc_pkg::os_t        os_out,           // to adc os pins
	output logic                convst_out,
	output logic                adc_reset_out,
	output logic                sclk_out,
	output logic                n_cs_out,
	output adc_pkg::chan_mask_t data_valid_out,   // one-hot pair strobe
	output adc_pkg::sample_t    data_a_out,
	output adc_pkg::sample_t    data_b_out
);

	logic shift_en;   // read fsm to shifter

	assign adc_reset_out = reset_in;   // adc reset follows system reset

	////////////////////////////////////////////////////////////
	// conversion and read run side by side
	////////////////////////////////////////////////////////////

	adc_convert_fsm #(
		.MIN_T_CYCLE(MIN_T_CYCLE),
		.OS_INIT(OS_INIT)
	) u_convert (
		.clk_in(clk_in),
		.reset_in(reset_in),
		.cstart_in(cstart_in),
		.busy_in(busy_in),
		.os_in(os_in),
		.update_in(update_in),
		.convst_out(convst_out),
		.os_out(os_out)
	);

	adc_read_fsm u_read (
		.clk_in(clk_in),
		.reset_in(reset_in),
		.busy_in(busy_in),
		.n_cs_out(n_cs_out),
		.sclk_out(sclk_out),
		.shift_en(shift_en)
	);

	adc_serial_shifter u_shifter (
		.clk_in(clk_in),
		.reset_in(reset_in),
		.shift_en(shift_en),
		.data_a_in(data_a_in),
		.data_b_in(data_b_in),
		.data_a_out(data_a_out),
		.data_b_out(data_b_out),
		.data_valid_out(data_valid_out)
	);

endmodule

// ==== adc_convert_fsm.sv ====
`timescale 1ns/1ps

module adc_convert_fsm #(
	parameter int MIN_T_CYCLE = 85,   // min conversion cycle in clk_in cycles
	parameter int OS_INIT     = 1     // oversampling code out of reset
) (
	input  logic         clk_in,
	input  logic         reset_in,
	input  logic         cstart_in,    // pulse starts continuous conversion
	input  logic         busy_in,      // adc converting
	input  adc_pkg::os_t os_in,        // front-panel oversampling code
	input  logic         update_in,    // latch os_in
	output logic         convst_out,   // active low convert start
	output adc_pkg::os_t os_out        // oversampling pins to adc
);

	// reset code, clamped like a front-panel update
	localparam adc_pkg::os_t OS_RST =
		(adc_pkg::os_t'(OS_INIT) < adc_pkg::OS_MIN) ? adc_pkg::OS_MIN : adc_pkg::os_t'(OS_INIT);

	adc_pkg::conv_state_t state;
	adc_pkg::conv_state_t next_state;
	logic                 state_change;
	logic                 cycle_done;     // min cycle time elapsed in CONV_WAIT

	////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			state <= adc_pkg::CONV_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;   // stay by default
		case (state)
			adc_pkg::CONV_IDLE: begin
				if (cstart_in) next_state = adc_pkg::CONV_START;
			end
			adc_pkg::CONV_START: begin
				next_state = adc_pkg::CONV_WAIT;   // single cycle pulse
			end
			adc_pkg::CONV_WAIT: begin
				if (cycle_done && !busy_in) next_state = adc_pkg::CONV_START;
			end
			default: next_state = adc_pkg::CONV_IDLE;
		endcase
	end

	assign state_change = (next_state != state);
	assign convst_out   = (state != adc_pkg::CONV_START);   // low only in CONV_START

	adc_state_counter #(
		.LIMIT(MIN_T_CYCLE)
	) u_conv_cnt (
		.clk_in(clk_in),
		.reset_in(reset_in),
		.state_change(state_change),
		.count(),
		.at_limit(cycle_done)
	);

	////////////////////////////////////////////////////////////
	// oversampling register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			os_out <= OS_RST;
		end else if (update_in) begin
			os_out <= (os_in < adc_pkg::OS_MIN) ? adc_pkg::OS_MIN : os_in;   // clamp low codes
		end
	end

	// convst never overlaps a running conversion
	a_convst_not_busy : assert property (@(posedge clk_in) disable iff (reset_in)
		!convst_out |-> !busy_in);

	a_os_min : assert property (@(posedge clk_in) disable iff (reset_in)
		os_out >= adc_pkg::OS_MIN);

endmodule

// ==== adc_pkg.sv ====
package adc_pkg;

	////////////////////////////////////////////////////////////
	// frame geometry
	////////////////////////////////////////////////////////////

	localparam int SAMPLE_W       = 18;                          // bits per conversion result
	localparam int N_CHAN         = 8;                           // channels per frame
	localparam int WORDS_PER_LINE = N_CHAN / 2;                  // line a and line b split them
	localparam int RD_LENGTH      = SAMPLE_W * WORDS_PER_LINE;   // bits per line per frame, 72
	localparam int CNT_W          = 8;                           // state counter width

	////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////

	typedef logic signed [SAMPLE_W-1:0] sample_t;   // one adc word, two's complement
	typedef logic [2:0]                 os_t;       // oversampling code, ratio 2^os
	typedef logic [N_CHAN-1:0]          chan_mask_t; // bit i line a word i, bit i+4 line b
	typedef logic [CNT_W-1:0]           cnt_t;      // cycles spent in a state

	// eight channels need an oversampling ratio of 2 or more
	localparam os_t OS_MIN = 3'd1;

	typedef enum logic [1:0] {
		CONV_IDLE  = 2'd0,   // wait for cstart
		CONV_START = 2'd1,   // convst low for one cycle
		CONV_WAIT  = 2'd2    // min cycle time and busy low
	} conv_state_t;

	typedef enum logic [1:0] {
		READ_IDLE  = 2'd0,   // wait for busy rise
		READ_SHIFT = 2'd1,   // cs low, sclk running
		READ_DRAIN = 2'd2    // wait for busy fall
	} read_state_t;

endpackage

// ==== adc_read_fsm.sv ====
`timescale 1ns/1ps

module adc_read_fsm (
	input  logic clk_in,
	input  logic reset_in,
	input  logic busy_in,    // rising edge starts a frame
	output logic n_cs_out,   // active low chip select
	output logic sclk_out,   // gated copy of clk_in, idles high
	output logic shift_en    // shifter samples on the next rise
);

	adc_pkg::read_state_t state;
	adc_pkg::read_state_t next_state;
	logic                 state_change;
	adc_pkg::cnt_t        rd_count;     // bits clocked so far in READ_SHIFT
	logic                 frame_done;   // all RD_LENGTH bits clocked

	////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			state <= adc_pkg::READ_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			adc_pkg::READ_IDLE: begin
				if (busy_in) next_state = adc_pkg::READ_SHIFT;   // new conversion running
			end
			adc_pkg::READ_SHIFT: begin
				if (frame_done) next_state = adc_pkg::READ_DRAIN;
			end
			adc_pkg::READ_DRAIN: begin
				if (!busy_in) next_state = adc_pkg::READ_IDLE;    // one cycle if busy already low
			end
			default: next_state = adc_pkg::READ_IDLE;
		endcase
	end

	assign state_change = (next_state != state);

	adc_state_counter #(
		.LIMIT(adc_pkg::RD_LENGTH)
	) u_read_cnt (
		.clk_in(clk_in),
		.reset_in(reset_in),
		.state_change(state_change),
		.count(rd_count),
		.at_limit(frame_done)
	);

	////////////////////////////////////////////////////////////
	// chip select and serial clock
	////////////////////////////////////////////////////////////

	// cs low for counts 0 to RD_LENGTH-1 of READ_SHIFT
	assign n_cs_out = !((state == adc_pkg::READ_SHIFT) &&
		(rd_count < adc_pkg::cnt_t'(adc_pkg::RD_LENGTH)));
	assign shift_en = !n_cs_out;

	// cs moves just after a rise while clk is high, so no runt pulse
	// adc drives bit k on sclk fall k, taken on the following clk rise
	assign sclk_out = n_cs_out ? 1'b1 : clk_in;

	// cs low only in READ_SHIFT, and only entered from READ_IDLE
	a_cs_in_shift : assert property (@(posedge clk_in) disable iff (reset_in)
		!n_cs_out |-> (state == adc_pkg::READ_SHIFT) &&
		(($past(state) == adc_pkg::READ_IDLE) || !$past(n_cs_out)));

endmodule

// ==== adc_serial_shifter.sv ====
`timescale 1ns/1ps

module adc_serial_shifter (
	input  logic                clk_in,
	input  logic                reset_in,
	input  logic                shift_en,         // cs low, take a bit on each rise
	input  logic                data_a_in,        // serial line a
	input  logic                data_b_in,        // serial line b
	output adc_pkg::sample_t    data_a_out,       // last complete line a word
	output adc_pkg::sample_t    data_b_out,       // last complete line b word
	output adc_pkg::chan_mask_t data_valid_out    // one cycle strobe per word pair
);

	localparam int BIT_W  = $clog2(adc_pkg::SAMPLE_W);
	localparam int WORD_W = $clog2(adc_pkg::WORDS_PER_LINE);

	adc_pkg::sample_t    shift_a;       // line a shift register
	adc_pkg::sample_t    shift_b;       // line b shift register
	logic [BIT_W-1:0]    bit_cnt;       // bit within word
	logic [WORD_W-1:0]   word_cnt;      // word within frame
	logic                word_done;     // 18th bit on the lines now
	adc_pkg::chan_mask_t word_mask;     // valid bits for word_cnt

	assign word_done = shift_en && (bit_cnt == BIT_W'(adc_pkg::SAMPLE_W - 1));

	always_comb begin
		word_mask = '0;
		word_mask[word_cnt] = 1'b1;                              // line a
		word_mask[word_cnt + adc_pkg::WORDS_PER_LINE] = 1'b1;    // line b
	end

	////////////////////////////////////////////////////////////
	// shift path, msb first
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (shift_en) begin
			shift_a <= {shift_a[adc_pkg::SAMPLE_W-2:0], data_a_in};
			shift_b <= {shift_b[adc_pkg::SAMPLE_W-2:0], data_b_in};
		end
	end

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			bit_cnt  <= '0;
			word_cnt <= '0;
		end else if (!shift_en) begin
			bit_cnt  <= '0;    // realign for next frame
			word_cnt <= '0;
		end else if (word_done) begin
			bit_cnt  <= '0;
			word_cnt <= word_cnt + 1'b1;
		end else begin
			bit_cnt  <= bit_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// word outputs
	////////////////////////////////////////////////////////////

	// last bit goes straight in, so the word shows the cycle after it is taken
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			data_a_out     <= '0;
			data_b_out     <= '0;
			data_valid_out <= '0;
		end else begin
			data_valid_out <= word_done ? word_mask : '0;
			if (word_done) begin
				data_a_out <= {shift_a[adc_pkg::SAMPLE_W-2:0], data_a_in};
				data_b_out <= {shift_b[adc_pkg::SAMPLE_W-2:0], data_b_in};
			end
		end
	end

	a_valid_pair : assert property (@(posedge clk_in) disable iff (reset_in)
		(data_valid_out == '0) || ($countones(data_valid_out) == 2));

endmodule

// ==== adc_state_counter.sv ====
`timescale 1ns/1ps

module adc_state_counter #(
	parameter int LIMIT = 1   // count value that raises at_limit
) (
	input  logic          clk_in,
	input  logic          reset_in,
	input  logic          state_change,   // high in the cycle before a new state
	output adc_pkg::cnt_t count,          // cycles in current state
	output logic          at_limit        // count has reached LIMIT
);

	localparam adc_pkg::cnt_t CNT_MAX = '1;   // saturation point

	////////////////////////////////////////////////////////////
	// cycle counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			count <= '0;
		end else if (state_change) begin
			count <= '0;                   // new state starts at zero
		end else if (count != CNT_MAX) begin
			count <= count + 1'b1;         // hold at top, no wrap
		end
	end

	assign at_limit = (count >= adc_pkg::cnt_t'(LIMIT));

	// a limit past the counter top would never be reached
	a_limit_fits : assert property (@(posedge clk_in) disable iff (reset_in)
		(LIMIT >= 0) && (LIMIT <= int'(CNT_MAX)));

endmodule

// ==== flist.f ====
adc_pkg.sv
adc_state_counter.sv
adc_convert_fsm.sv
adc_read_fsm.sv
adc_serial_shifter.sv
adc_controller.sv
tb_adc_model.sv
tb_adc_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the adc controller testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_adc_controller

status=0
./obj_dir/Vtb_adc_controller > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulator exited with status $status"
	exit "$status"
fi
exit 0

// ==== tb_adc_controller.sv ====
`timescale 1ns/1ps

module tb_adc_controller;

	localparam int N_ROWS = 6;
	localparam int MIN_T  = 40;   // min cycle handed to the dut

	logic                clk_in;
	logic                reset_in;
	logic                busy_in;
	logic                data_a_in;
	logic                data_b_in;
	logic                update_in;
	logic                cstart_in;
	adc_pkg::os_t        os_in;
	adc_pkg::os_t        os_out;
	logic                convst_out;
	logic                adc_reset_out;
	logic                sclk_out;
	logic                n_cs_out;
	adc_pkg::chan_mask_t data_valid_out;
	adc_pkg::sample_t    data_a_out;
	adc_pkg::sample_t    data_b_out;
	adc_pkg::sample_t    row_samples [8];   // row the model sends next

	////////////////////////////////////////////////////////////
	// stimulus table, one row per frame
	////////////////////////////////////////////////////////////

	adc_pkg::os_t tbl_os [N_ROWS] = '{3'd0, 3'd3, 3'd6, 3'd7, 3'd0, 3'd2};
	logic         tbl_upd [N_ROWS] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1};
	adc_pkg::sample_t tbl_smp [N_ROWS][8] = '{
		'{18'h1FFFF, 18'h20000, 18'h00000, 18'h3FFFF, 18'h15555, 18'h2AAAA, 18'h00001, 18'h3FFFE},
		'{18'h12345, 18'h2DCBA, 18'h00100, 18'h3FF00, 18'h0F0F0, 18'h30F0F, 18'h1FFFE, 18'h20001},
		'{18'h00002, 18'h3FFFD, 18'h18000, 18'h28000, 18'h0ABCD, 18'h35432, 18'h00800, 18'h3F800},
		'{18'h20000, 18'h20000, 18'h1FFFF, 18'h1FFFF, 18'h00000, 18'h00000, 18'h3FFFF, 18'h3FFFF},
		'{18'h01234, 18'h3EDCC, 18'h11111, 18'h2EEEF, 18'h05A5A, 18'h3A5A6, 18'h1C71C, 18'h238E4},
		'{18'h00000, 18'h3FFFF, 18'h00001, 18'h3FFFE, 18'h1FFFF, 18'h20000, 18'h10000, 18'h30000}
	};
	adc_pkg::chan_mask_t exp_mask [4] = '{8'h11, 8'h22, 8'h44, 8'h88};   // word k pairs k, k+4

	int            cyc;          // cycles since reset release
	int            last_conv;    // cycle of the previous convst, -1 before the first
	int            first_due;    // cycle the first convst must show
	logic          prev_convst;
	logic          prev_ncs;
	logic          prev_busy;
	adc_pkg::cnt_t sclk_falls;   // falls within the current cs window
	logic          in_frame = 1'b0;

	adc_controller #(
		.MIN_T_CYCLE(MIN_T),
		.OS_INIT(1)
	) u_dut (.*);

	tb_adc_model u_adc (
		.clk_in(clk_in),
		.adc_reset(adc_reset_out),
		.convst(convst_out),
		.n_cs(n_cs_out),
		.sclk(sclk_out),
		.samples(row_samples),
		.busy(busy_in),
		.data_a(data_a_in),
		.data_b(data_b_in)
	);

	always #50 clk_in = ~clk_in;   // 100 ns period

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic stop_on_error();
		$display("Test failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_timeout(input string what);
		$display("timed out waiting for %s at %0t ns", what, $time);
		stop_on_error();
	endtask

	task automatic check_sample(input string name, input adc_pkg::sample_t exp,
			input adc_pkg::sample_t act);
		if (act !== exp) begin
			$display("[FAIL] time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_mask(input string name, input adc_pkg::chan_mask_t exp,
			input adc_pkg::chan_mask_t act);
		if (act !== exp) begin
			$display("[FAIL] time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_os(input string name, input adc_pkg::os_t exp, input adc_pkg::os_t act);
		if (act !== exp) begin
			$display("[FAIL] time=%0t signal=%s expected=%0d actual=%0d", $time, name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_count(input string name, input adc_pkg::cnt_t exp,
			input adc_pkg::cnt_t act);
		if (act !== exp) begin
			$display("[FAIL] time=%0t signal=%s expected=%0d actual=%0d", $time, name, exp, act);
			stop_on_error();
		end
	endtask

	////////////////////////////////////////////////////////////
	// waits, each with its own limit
	////////////////////////////////////////////////////////////

	task automatic await_frame();
		int n;
		n = 0;
		while (n_cs_out !== 1'b0) begin
			@(posedge clk_in);
			n++;
			if (n > 400) report_timeout("chip select to fall");
		end
	endtask

	task automatic next_strobe();
		int n;
		n = 0;
		do begin
			@(posedge clk_in);
			n++;
			if (n > 40) report_timeout("a valid strobe");
		end while (data_valid_out === '0);
	endtask

	task automatic frame_end();
		int n;
		n = 0;
		while (n_cs_out !== 1'b1) begin
			@(posedge clk_in);
			n++;
			if (n > 200) report_timeout("chip select to rise");
		end
	endtask

	////////////////////////////////////////////////////////////
	// monitors
	////////////////////////////////////////////////////////////

	always @(posedge clk_in) begin
		if (reset_in) begin
			cyc         <= 0;
			last_conv   <= -1;
			first_due   <= -1;
			prev_convst <= 1'b1;
			prev_ncs    <= 1'b1;
			prev_busy   <= 1'b0;
		end else begin
			cyc <= cyc + 1;
			if (!convst_out) begin
				check_bit("busy_in during convst", 1'b0, busy_in);
				check_bit("convst_out one cycle before", 1'b1, prev_convst);   // one cycle wide
				if (last_conv < 0 && cyc != first_due) begin
					$display("first convst at cycle %0d, due at cycle %0d", cyc, first_due);
					stop_on_error();
				end
				if (last_conv >= 0 && cyc - last_conv < MIN_T + 2) begin
					$display("convst pulses only %0d cycles apart", cyc - last_conv);
					stop_on_error();
				end
				last_conv <= cyc;
			end
			if (cstart_in && first_due < 0) first_due <= cyc + 1;
			if (!n_cs_out && prev_ncs) check_bit("busy_in before cs fall", 1'b1, prev_busy);
			prev_convst <= convst_out;
			prev_ncs    <= n_cs_out;
			prev_busy   <= busy_in;
		end
	end

	// cs edges never meet an sclk edge, so the branches stay apart
	always @(negedge sclk_out or n_cs_out) begin
		if (n_cs_out === 1'b0 && sclk_out === 1'b1) begin
			sclk_falls = '0;   // window opens
			in_frame   = 1'b1;
		end else if (n_cs_out === 1'b1 && in_frame) begin
			check_count("sclk falls per frame", adc_pkg::cnt_t'(adc_pkg::RD_LENGTH), sclk_falls);
			in_frame = 1'b0;
		end else if (n_cs_out === 1'b0 && sclk_out === 1'b0) begin
			sclk_falls = sclk_falls + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int           r;
		int           w;
		adc_pkg::os_t exp_os;
		void'($urandom(32'h2488));
		clk_in = 1'b0;
		reset_in  <= 1'b1;
		os_in     <= '0;
		update_in <= 1'b0;
		cstart_in <= 1'b0;
		for (w = 0; w < 8; w++) row_samples[w] <= '0;
		repeat (2) @(posedge clk_in);
		check_bit("adc_reset_out", 1'b1, adc_reset_out);
		@(posedge clk_in);
		reset_in <= 1'b0;
		@(posedge clk_in);
		check_bit("adc_reset_out", 1'b0, adc_reset_out);
		check_bit("convst_out", 1'b1, convst_out);
		check_bit("n_cs_out", 1'b1, n_cs_out);
		check_bit("sclk_out", 1'b1, sclk_out);
		check_mask("data_valid_out", '0, data_valid_out);
		check_sample("data_a_out", '0, data_a_out);
		check_sample("data_b_out", '0, data_b_out);
		exp_os = 3'd1;   // OS_INIT of 1 passes the clamp
		check_os("os_out", exp_os, os_out);
		for (r = 0; r < N_ROWS; r++) begin
			for (w = 0; w < 8; w++) row_samples[w] <= tbl_smp[r][w];
			os_in     <= tbl_os[r];
			update_in <= tbl_upd[r];
			@(posedge clk_in);
			update_in <= 1'b0;
			if (tbl_upd[r]) exp_os = (tbl_os[r] == 3'd0) ? 3'd1 : tbl_os[r];   // code 0 reads 1
			@(posedge clk_in);
			check_os("os_out", exp_os, os_out);
			if (r == 0) begin
				cstart_in <= 1'b1;
				@(posedge clk_in);
				cstart_in <= 1'b0;
			end
			await_frame();
			for (w = 0; w < 4; w++) begin
				next_strobe();
				check_mask("data_valid_out", exp_mask[w], data_valid_out);
				check_sample("data_a_out", tbl_smp[r][w], data_a_out);
				check_sample("data_b_out", tbl_smp[r][w+4], data_b_out);
			end
			frame_end();
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== tb_adc_model.sv ====
`timescale 1ns/1ps

module tb_adc_model (
	input  logic             clk_in,
	input  logic             adc_reset,     // reset pin, from dut
	input  logic             convst,        // active low start
	input  logic             n_cs,          // chip select from dut
	input  logic             sclk,          // gated serial clock
	input  adc_pkg::sample_t samples [8],   // words 0-3 line a, 4-7 line b
	output logic             busy,
	output logic             data_a,
	output logic             data_b
);

	int unsigned                   busy_left;   // busy cycles still to run
	logic [adc_pkg::RD_LENGTH-1:0] frame_a;     // word 0 in the top bits
	logic [adc_pkg::RD_LENGTH-1:0] frame_b;
	int                            bit_idx;     // next frame bit to drive

	////////////////////////////////////////////////////////////
	// conversion timing
	////////////////////////////////////////////////////////////

	always @(posedge clk_in or posedge adc_reset) begin
		if (adc_reset) begin
			busy      <= 1'b0;
			busy_left <= 0;
		end else if (!convst) begin
			busy      <= 1'b1;                    // convst seen low
			busy_left <= 20 + ($urandom % 41);    // 20 to 60 cycles
		end else if (busy_left > 1) begin
			busy_left <= busy_left - 1;
		end else begin
			busy      <= 1'b0;
			busy_left <= 0;
		end
	end

	////////////////////////////////////////////////////////////
	// serial output, two lines
	////////////////////////////////////////////////////////////

	// cs falls and rises while clk is high, so sclk holds still then
	always @(negedge n_cs or negedge sclk or posedge adc_reset) begin
		if (adc_reset) begin
			data_a  <= 1'b0;
			data_b  <= 1'b0;
			bit_idx <= 0;
		end else if (n_cs === 1'b0 && sclk === 1'b1) begin
			frame_a <= {samples[0], samples[1], samples[2], samples[3]};
			frame_b <= {samples[4], samples[5], samples[6], samples[7]};
			data_a  <= samples[0][adc_pkg::SAMPLE_W-1];   // msb out with cs
			data_b  <= samples[4][adc_pkg::SAMPLE_W-1];
			bit_idx <= 0;
		end else if (n_cs === 1'b0 && bit_idx < adc_pkg::RD_LENGTH) begin
			data_a  <= frame_a[adc_pkg::RD_LENGTH-1-bit_idx];   // fall k drives bit k
			data_b  <= frame_b[adc_pkg::RD_LENGTH-1-bit_idx];
			bit_idx <= bit_idx + 1;
		end
	end

endmodule
